//--- src/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Feature, weight and attention element width
  localparam int DATA_WIDTH     = 8;
  localparam int NUM_FEATURE_IN = 8;
  localparam int COL_IDX_WIDTH  = 3;
  localparam int ROW_LEN_WIDTH  = 4;

  localparam int MAX_NODES      = 4;
  localparam int NUM_NODE_WIDTH = 3;

  // 8 entries of 8x8 products fit in 20 bits
  localparam int WH_DATA_WIDTH  = 20;
  localparam int COEF_WIDTH     = 32;

  localparam int WGT_ADDR_WIDTH = 7;
  localparam int H_WORD_WIDTH   = 11;

  // Stream word, read as header or as entry depending on position in the row
  typedef union packed {
    struct packed {
      logic [H_WORD_WIDTH-NUM_NODE_WIDTH-ROW_LEN_WIDTH-1:0] pad;
      logic [NUM_NODE_WIDTH-1:0]                            num_nodes;
      logic [ROW_LEN_WIDTH-1:0]                             row_len;
    } hdr;
    struct packed {
      logic signed [DATA_WIDTH-1:0] value;
      logic [COL_IDX_WIDTH-1:0]     col;
    } ent;
  } h_word_u;

endpackage

`default_nettype wire

//--- src/row_if.sv
`default_nettype none

interface row_if import gat_pkg::*; ();

  // One strobe per sparse entry
  logic                         entry_vld;
  logic signed [DATA_WIDTH-1:0] value;
  logic [COL_IDX_WIDTH-1:0]     col;

  // Row and node tags, valid with entry_vld
  logic                         row_end;
  logic [NUM_NODE_WIDTH-1:0]    node_idx;
  logic                         node_first;
  logic                         node_last;

  modport ctrl (
    output entry_vld, value, col,
    output row_end, node_idx, node_first, node_last
  );

  modport data (
    input entry_vld, value, col,
    input row_end, node_idx, node_first, node_last
  );

endinterface

`default_nettype wire

//--- src/wh_if.sv
`default_nettype none

interface wh_if import gat_pkg::*; #(
  parameter int NUM_FEATURE_OUT = 4
) ();

  logic                                          wh_vld;
  // Element 0 in the low bits
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh;
  logic [NUM_NODE_WIDTH-1:0]                     node_idx;
  logic                                          node_first;
  logic                                          node_last;

  modport src (
    output wh_vld, wh, node_idx, node_first, node_last
  );

  modport sink (
    input wh_vld, wh, node_idx, node_first, node_last
  );

endinterface

`default_nettype wire

//--- src/gat_ctrl.sv
`default_nettype none

module gat_ctrl import gat_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  input  logic    h_vld_i,
  input  h_word_u h_word_i,

  row_if.ctrl     row_o
);

  localparam logic ST_HDR = 1'b0;
  localparam logic ST_ENT = 1'b1;

  logic                      state;
  logic [ROW_LEN_WIDTH-1:0]  ent_left;
  logic [NUM_NODE_WIDTH-1:0] node_cnt;
  logic [NUM_NODE_WIDTH-1:0] num_nodes;
  logic                      last_node;
  logic                      last_ent;
  logic                      ent_acc;

  assign last_node = (node_cnt == num_nodes - 1'b1);
  assign last_ent  = (ent_left == ROW_LEN_WIDTH'(1));
  assign ent_acc   = h_vld_i && (state == ST_ENT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_HDR;
      ent_left  <= '0;
      node_cnt  <= '0;
      num_nodes <= '0;
    end else if (h_vld_i) begin
      if (state == ST_HDR) begin
        ent_left <= h_word_i.hdr.row_len;
        // Later headers of the subgraph repeat the count
        if (node_cnt == '0) begin
          num_nodes <= h_word_i.hdr.num_nodes;
        end
        state <= ST_ENT;
      end else begin
        ent_left <= ent_left - 1'b1;
        if (last_ent) begin
          state <= ST_HDR;
          if (last_node) begin
            node_cnt <= '0;
          end else begin
            node_cnt <= node_cnt + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_o.entry_vld <= 1'b0;
    end else begin
      row_o.entry_vld <= ent_acc;
    end
  end

  // Entry payload and tags
  always_ff @(posedge clk) begin
    if (ent_acc) begin
      row_o.value      <= h_word_i.ent.value;
      row_o.col        <= h_word_i.ent.col;
      row_o.row_end    <= last_ent;
      row_o.node_idx   <= node_cnt;
      row_o.node_first <= (node_cnt == '0);
      row_o.node_last  <= last_node;
    end
  end

  a_row_len: assert property (
    @(posedge clk) disable iff (!rst_n)
    (h_vld_i && state == ST_HDR) |->
      (h_word_i.hdr.row_len != '0 && h_word_i.hdr.row_len <= NUM_FEATURE_IN)
  ) else $error("gat_ctrl: header row_len out of range");

  a_num_nodes: assert property (
    @(posedge clk) disable iff (!rst_n)
    (h_vld_i && state == ST_HDR && node_cnt == '0) |->
      (h_word_i.hdr.num_nodes != '0 && h_word_i.hdr.num_nodes <= MAX_NODES)
  ) else $error("gat_ctrl: subgraph num_nodes out of range");

endmodule

`default_nettype wire

//--- src/weight_bank.sv
`default_nettype none

module weight_bank import gat_pkg::*; #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  input  logic                                       wgt_wr_i,
  input  logic [WGT_ADDR_WIDTH-1:0]                  wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]                      wgt_data_i,

  input  logic [COL_IDX_WIDTH-1:0]                   rd_col_i,
  output logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row_o,
  output logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_src_o,
  output logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_dst_o
);

  localparam int WGT_DEPTH = (NUM_FEATURE_IN + 2) * NUM_FEATURE_OUT;
  localparam int ROW_W     = $clog2(NUM_FEATURE_IN + 2);
  localparam int ELEM_W    = (NUM_FEATURE_OUT > 1) ? $clog2(NUM_FEATURE_OUT) : 1;

  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_mem [NUM_FEATURE_IN];
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_src;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_dst;

  logic [ROW_W-1:0]  wr_row;
  logic [ELEM_W-1:0] wr_elem;

  // Rows past the last W row hold the source then the destination half
  assign wr_row  = ROW_W'(wgt_addr_i / NUM_FEATURE_OUT);
  assign wr_elem = ELEM_W'(wgt_addr_i % NUM_FEATURE_OUT);

  always_ff @(posedge clk) begin
    if (wgt_wr_i) begin
      if (wr_row < ROW_W'(NUM_FEATURE_IN)) begin
        w_mem[wr_row[COL_IDX_WIDTH-1:0]][wr_elem] <= wgt_data_i;
      end else if (wr_row == ROW_W'(NUM_FEATURE_IN)) begin
        a_src[wr_elem] <= wgt_data_i;
      end else if (wr_row == ROW_W'(NUM_FEATURE_IN + 1)) begin
        a_dst[wr_elem] <= wgt_data_i;
      end
    end
  end

  assign w_row_o = w_mem[rd_col_i];
  assign a_src_o = a_src;
  assign a_dst_o = a_dst;

  a_wr_addr: assert property (
    @(posedge clk) disable iff (!rst_n)
    wgt_wr_i |-> (wgt_addr_i < WGT_DEPTH)
  ) else $error("weight_bank: write address beyond weight store");

endmodule

`default_nettype wire

//--- src/spmm_row.sv
`default_nettype none

module spmm_row import gat_pkg::*; #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  row_if.data                                        row_i,

  output logic [COL_IDX_WIDTH-1:0]                   w_col_o,
  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row_i,

  wh_if.src                                          wh_o
);

  logic                            fresh;
  logic signed [WH_DATA_WIDTH-1:0] acc [NUM_FEATURE_OUT];
  logic signed [WH_DATA_WIDTH-1:0] sum [NUM_FEATURE_OUT];

  // W row lookup by the entry column
  assign w_col_o = row_i.col;

  for (genvar k = 0; k < NUM_FEATURE_OUT; k++) begin : g_mac
    logic signed [2*DATA_WIDTH-1:0]  prod;
    logic signed [WH_DATA_WIDTH-1:0] base;

    assign prod   = row_i.value * $signed(w_row_i[k]);
    assign base   = fresh ? '0 : acc[k];
    assign sum[k] = base + prod;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fresh       <= 1'b1;
      wh_o.wh_vld <= 1'b0;
    end else begin
      wh_o.wh_vld <= row_i.entry_vld & row_i.row_end;
      // Next row starts over right after row_end
      if (row_i.entry_vld) begin
        fresh <= row_i.row_end;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (row_i.entry_vld) begin
      for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
        acc[k] <= sum[k];
      end
      if (row_i.row_end) begin
        for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
          wh_o.wh[k] <= sum[k];
        end
        wh_o.node_idx   <= row_i.node_idx;
        wh_o.node_first <= row_i.node_first;
        wh_o.node_last  <= row_i.node_last;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/attn_coef.sv
`default_nettype none

module attn_coef import gat_pkg::*; #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  wh_if.sink                                         wh_i,

  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_src_i,
  input  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_dst_i,

  output logic                                       coef_vld_o,
  output logic [NUM_NODE_WIDTH-1:0]                  coef_node_o,
  output logic signed [COEF_WIDTH-1:0]               coef_o,
  output logic                                       coef_last_o
);

  logic signed [COEF_WIDTH-1:0] src_dot;
  logic signed [COEF_WIDTH-1:0] dst_dot;
  logic signed [COEF_WIDTH-1:0] src_hold;
  logic signed [COEF_WIDTH-1:0] src_term;
  logic                         seen_first;

  function automatic logic signed [COEF_WIDTH-1:0] dot(
    input logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0]    a,
    input logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] v
  );
    logic signed [COEF_WIDTH-1:0] s;
    s = '0;
    for (int k = 0; k < NUM_FEATURE_OUT; k++) begin
      s = s + $signed(a[k]) * $signed(v[k]);
    end
    return s;
  endfunction

  assign src_dot = dot(a_src_i, wh_i.wh);
  assign dst_dot = dot(a_dst_i, wh_i.wh);

  // Centre node term, fresh on node 0 and held for the rest
  assign src_term = wh_i.node_first ? src_dot : src_hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_vld_o  <= 1'b0;
      coef_last_o <= 1'b0;
      seen_first  <= 1'b0;
    end else begin
      coef_vld_o  <= wh_i.wh_vld;
      coef_last_o <= wh_i.wh_vld & wh_i.node_last;
      if (wh_i.wh_vld && wh_i.node_first) begin
        seen_first <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wh_i.wh_vld) begin
      coef_o      <= src_term + dst_dot;
      coef_node_o <= wh_i.node_idx;
      if (wh_i.node_first) begin
        src_hold <= src_dot;
      end
    end
  end

  a_centre_seen: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wh_i.wh_vld && !wh_i.node_first) |-> seen_first
  ) else $error("attn_coef: neighbour row before any centre row");

endmodule

`default_nettype wire

//--- src/gat_layer_top.sv
`default_nettype none

module gat_layer_top import gat_pkg::*; #(
  parameter int NUM_FEATURE_OUT = 4
) (
  input  logic                                     clk,
  input  logic                                     rst_n,

  input  logic                                     wgt_wr_i,
  input  logic [WGT_ADDR_WIDTH-1:0]                wgt_addr_i,
  input  logic [DATA_WIDTH-1:0]                    wgt_data_i,

  input  logic                                     h_vld_i,
  input  logic [H_WORD_WIDTH-1:0]                  h_word_i,

  output logic                                     wh_vld_o,
  output logic [NUM_NODE_WIDTH-1:0]                wh_node_o,
  output logic [NUM_FEATURE_OUT*WH_DATA_WIDTH-1:0] wh_data_o,

  output logic                                     coef_vld_o,
  output logic [NUM_NODE_WIDTH-1:0]                coef_node_o,
  output logic signed [COEF_WIDTH-1:0]             coef_o,
  output logic                                     coef_last_o
);

  logic [COL_IDX_WIDTH-1:0]                   w_col;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] w_row;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_src;
  logic [NUM_FEATURE_OUT-1:0][DATA_WIDTH-1:0] a_dst;

  row_if u_row_if ();
  wh_if #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_wh_if ();

  gat_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .h_vld_i  (h_vld_i),
    .h_word_i (h_word_i),
    .row_o    (u_row_if.ctrl)
  );

  weight_bank #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_bank (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_wr_i   (wgt_wr_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i),
    .rd_col_i   (w_col),
    .w_row_o    (w_row),
    .a_src_o    (a_src),
    .a_dst_o    (a_dst)
  );

  spmm_row #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_spmm (
    .clk     (clk),
    .rst_n   (rst_n),
    .row_i   (u_row_if.data),
    .w_col_o (w_col),
    .w_row_i (w_row),
    .wh_o    (u_wh_if.src)
  );

  attn_coef #(.NUM_FEATURE_OUT(NUM_FEATURE_OUT)) u_coef (
    .clk         (clk),
    .rst_n       (rst_n),
    .wh_i        (u_wh_if.sink),
    .a_src_i     (a_src),
    .a_dst_i     (a_dst),
    .coef_vld_o  (coef_vld_o),
    .coef_node_o (coef_node_o),
    .coef_o      (coef_o),
    .coef_last_o (coef_last_o)
  );

  // Finished WH rows also leave at the top
  assign wh_vld_o  = u_wh_if.wh_vld;
  assign wh_node_o = u_wh_if.node_idx;
  assign wh_data_o = u_wh_if.wh;

endmodule

`default_nettype wire

//--- sim/tb_gat_model.svh
`ifndef TB_GAT_MODEL_SVH
`define TB_GAT_MODEL_SVH

// Expected WH row, with the cycle in which it must appear
typedef struct packed {
  int unsigned                          due;
  logic [NUM_NODE_WIDTH-1:0]            node;
  logic [NFO*WH_DATA_WIDTH-1:0]         data;
} wh_exp_t;

typedef struct packed {
  int unsigned                          due;
  logic                                 last;
  logic [NUM_NODE_WIDTH-1:0]            node;
  logic signed [COEF_WIDTH-1:0]         coef;
} coef_exp_t;

wh_exp_t   exp_wh_q[$];
coef_exp_t exp_coef_q[$];

// Model copy of the weight store
logic signed [DATA_WIDTH-1:0] w_mdl [NUM_FEATURE_IN][NFO];
logic signed [DATA_WIDTH-1:0] a_src_mdl [NFO];
logic signed [DATA_WIDTH-1:0] a_dst_mdl [NFO];

int unsigned lcg_state = 64234;

function automatic int unsigned lcg_next(input int unsigned range);
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return (lcg_state >> 16) % range;
endfunction

function automatic logic [NFO*WH_DATA_WIDTH-1:0] pack_row(input int v [NFO]);
  logic [NFO*WH_DATA_WIDTH-1:0] r;
  for (int k = 0; k < NFO; k++) begin
    r[k*WH_DATA_WIDTH +: WH_DATA_WIDTH] = WH_DATA_WIDTH'(v[k]);
  end
  return r;
endfunction

function automatic int attn_dot(input logic signed [DATA_WIDTH-1:0] a [NFO], input int v [NFO]);
  int s;
  s = 0;
  for (int k = 0; k < NFO; k++) begin
    s += int'(a[k]) * v[k];
  end
  return s;
endfunction

`endif

//--- sim/tb_gat_layer.sv
`default_nettype none

module tb_gat_layer import gat_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NFO = 4;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             wgt_wr_i;
  logic [WGT_ADDR_WIDTH-1:0]        wgt_addr_i;
  logic [DATA_WIDTH-1:0]            wgt_data_i;
  logic                             h_vld_i;
  logic [H_WORD_WIDTH-1:0]          h_word_i;
  logic                             wh_vld_o;
  logic [NUM_NODE_WIDTH-1:0]        wh_node_o;
  logic [NFO*WH_DATA_WIDTH-1:0]     wh_data_o;
  logic                             coef_vld_o;
  logic [NUM_NODE_WIDTH-1:0]        coef_node_o;
  logic signed [COEF_WIDTH-1:0]     coef_o;
  logic                             coef_last_o;

  int unsigned cyc = 0;
  int          wh_errs = 0;
  int          coef_errs = 0;
  int          idle_errs = 0;
  int          timeouts = 0;
  logic        stream_seen = 1'b0;
  logic        wh_hit = 1'b0;
  logic        coef_hit = 1'b0;

  `include "tb_gat_model.svh"

  wh_exp_t   wh_cur;
  coef_exp_t coef_cur;

  gat_layer_top #(.NUM_FEATURE_OUT(NFO)) dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_i    (wgt_wr_i),
    .wgt_addr_i  (wgt_addr_i),
    .wgt_data_i  (wgt_data_i),
    .h_vld_i     (h_vld_i),
    .h_word_i    (h_word_i),
    .wh_vld_o    (wh_vld_o),
    .wh_node_o   (wh_node_o),
    .wh_data_o   (wh_data_o),
    .coef_vld_o  (coef_vld_o),
    .coef_node_o (coef_node_o),
    .coef_o      (coef_o),
    .coef_last_o (coef_last_o)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Take the next expected result once the outputs have settled
  always @(posedge clk) begin
    #2;
    if (wh_vld_o) begin
      wh_hit = (exp_wh_q.size() > 0);
      if (wh_hit) begin
        wh_cur = exp_wh_q.pop_front();
      end
    end
    if (coef_vld_o) begin
      coef_hit = (exp_coef_q.size() > 0);
      if (coef_hit) begin
        coef_cur = exp_coef_q.pop_front();
      end
    end
  end

  a_quiet: assert property (@(negedge clk) disable iff (!rst_n)
    !stream_seen |-> (!wh_vld_o && !coef_vld_o && !coef_last_o))
    else begin
      idle_errs++;
      $display("Output strobe seen at %0t ns before any stream was sent", $time);
    end

  a_wh_pending: assert property (@(negedge clk) disable iff (!rst_n) wh_vld_o |-> wh_hit)
    else begin
      wh_errs++;
      $display("WH row appeared at %0t ns with no row expected", $time);
    end

  a_wh_value: assert property (@(negedge clk) disable iff (!rst_n)
    (wh_vld_o && wh_hit) |-> (wh_data_o == wh_cur.data && wh_node_o == wh_cur.node))
    else begin
      wh_errs++;
      $display("Error at %0t ns: WH node %0d data %h, expected node %0d data %h",
               $time, wh_node_o, wh_data_o, wh_cur.node, wh_cur.data);
    end

  a_wh_cycle: assert property (@(negedge clk) disable iff (!rst_n)
    (wh_vld_o && wh_hit) |-> (wh_cur.due == cyc))
    else begin
      wh_errs++;
      $display("Error at %0t ns: WH row in cycle %0d, expected cycle %0d",
               $time, cyc, wh_cur.due);
    end

  a_coef_pending: assert property (@(negedge clk) disable iff (!rst_n) coef_vld_o |-> coef_hit)
    else begin
      coef_errs++;
      $display("Coefficient appeared at %0t ns with none expected", $time);
    end

  a_coef_value: assert property (@(negedge clk) disable iff (!rst_n)
    (coef_vld_o && coef_hit) |-> (coef_o == coef_cur.coef && coef_node_o == coef_cur.node &&
                                  coef_last_o == coef_cur.last && coef_cur.due == cyc))
    else begin
      coef_errs++;
      $display("Error at %0t ns: coef node %0d value %0d last %b cycle %0d, expected %0d %0d %b %0d",
               $time, coef_node_o, coef_o, coef_last_o, cyc,
               coef_cur.node, coef_cur.coef, coef_cur.last, coef_cur.due);
    end

  a_last_strobe: assert property (@(negedge clk) disable iff (!rst_n) coef_last_o |-> coef_vld_o)
    else begin
      coef_errs++;
      $display("Error at %0t ns: coef_last_o high without coef_vld_o", $time);
    end

  task automatic load_weights();
    logic [DATA_WIDTH-1:0] d;
    for (int r = 0; r < NUM_FEATURE_IN + 2; r++) begin
      for (int k = 0; k < NFO; k++) begin
        d = DATA_WIDTH'(lcg_next(256));
        if (r < NUM_FEATURE_IN) begin
          w_mdl[r][k] = d;
        end else if (r == NUM_FEATURE_IN) begin
          a_src_mdl[k] = d;
        end else begin
          a_dst_mdl[k] = d;
        end
        @(posedge clk);
        #1;
        wgt_wr_i   = 1'b1;
        wgt_addr_i = WGT_ADDR_WIDTH'(r * NFO + k);
        wgt_data_i = d;
      end
    end
    @(posedge clk);
    #1;
    wgt_wr_i = 1'b0;
  endtask

  task automatic send_word(input logic [H_WORD_WIDTH-1:0] word, input int gap_max);
    int gap;
    gap = (gap_max > 0) ? int'(lcg_next(gap_max + 1)) : 0;
    repeat (gap) begin
      @(posedge clk);
      #1;
      h_vld_i = 1'b0;
    end
    @(posedge clk);
    #1;
    h_vld_i     = 1'b1;
    h_word_i    = word;
    stream_seen = 1'b1;
  endtask

  task automatic send_subgraph(input int n, input int gap_max, input bit short_rows);
    int        sums [NFO];
    int        src_term;
    int        len;
    int        v;
    int        c;
    wh_exp_t   we;
    coef_exp_t ce;
    src_term = 0;
    for (int j = 0; j < n; j++) begin
      len = short_rows ? 1 : 1 + int'(lcg_next(8));
      send_word({4'b0, 3'(n), 4'(len)}, gap_max);
      for (int k = 0; k < NFO; k++) begin
        sums[k] = 0;
      end
      for (int e = 0; e < len; e++) begin
        v = int'(lcg_next(256)) - 128;
        c = int'(lcg_next(8));
        for (int k = 0; k < NFO; k++) begin
          sums[k] += v * int'(w_mdl[c][k]);
        end
        send_word({8'(v), 3'(c)}, gap_max);
      end
      // Centre node term comes from node 0
      if (j == 0) begin
        src_term = attn_dot(a_src_mdl, sums);
      end
      we.due  = cyc + 2;
      we.node = 3'(j);
      we.data = pack_row(sums);
      exp_wh_q.push_back(we);
      ce.due  = cyc + 3;
      ce.last = (j == n - 1);
      ce.node = 3'(j);
      ce.coef = src_term + attn_dot(a_dst_mdl, sums);
      exp_coef_q.push_back(ce);
    end
  endtask

  task automatic drain_queues();
    int waited;
    @(posedge clk);
    #1;
    h_vld_i = 1'b0;
    waited  = 0;
    while ((exp_wh_q.size() > 0 || exp_coef_q.size() > 0) && waited < 60) begin
      @(posedge clk);
      waited++;
    end
    if (exp_wh_q.size() > 0 || exp_coef_q.size() > 0) begin
      timeouts++;
      $display("Timed out at %0t ns waiting for %0d WH rows and %0d coefficients",
               $time, exp_wh_q.size(), exp_coef_q.size());
    end
    repeat (4) @(posedge clk);
  endtask

  initial begin
    rst_n      = 1'b0;
    wgt_wr_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    h_vld_i    = 1'b0;
    h_word_i   = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (5) @(posedge clk);
    load_weights();
    repeat (5) @(posedge clk);

    // Random gaps between words
    for (int i = 0; i < 8; i++) begin
      send_subgraph(1 + int'(lcg_next(4)), 3, 1'b0);
    end
    drain_queues();

    // Back to back, with single nodes and single entries
    send_subgraph(1, 0, 1'b1);
    send_subgraph(3, 0, 1'b1);
    send_subgraph(1, 0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      send_subgraph(1 + int'(lcg_next(4)), 0, 1'b0);
    end
    drain_queues();

    load_weights();
    for (int i = 0; i < 6; i++) begin
      send_subgraph(1 + int'(lcg_next(4)), 1, 1'b0);
    end
    drain_queues();

    $display("Errors: wh %0d, coef %0d, idle %0d, timeouts %0d",
             wh_errs, coef_errs, idle_errs, timeouts);
    if (wh_errs + coef_errs + idle_errs + timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/gat_pkg.sv
src/row_if.sv
src/wh_if.sv
src/gat_ctrl.sv
src/weight_bank.sv
src/spmm_row.sv
src/attn_coef.sv
src/gat_layer_top.sv
+incdir+sim
sim/tb_gat_layer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f filelist.f --top-module tb_gat_layer -Mdir obj_dir

out=$(./obj_dir/Vtb_gat_layer) || true
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
